// ==== flist.f ====
mem_pkg.sv
outstanding_counter.sv
read_router.sv
write_router.sv
itcm_ram.sv
perip_regs.sv
mems.sv
tb_clk_gen.sv
tb_mems.sv

// ==== tb_mems.sv ====
// random single-beat traffic on both masters, checked against a word model
// m0 reads itcm slots 0-7 only and m1 writes slots 8-15 only, so no write/read races
module tb_mems
    import mem_pkg::*;
;

    logic  clk, rst_n;
    // channel 0 = m0 read, 1 = m1 read, 2 = m1 write
    logic  req_valid [3];
    id_t   req_id [3];
    addr_t req_addr [3];
    logic  rsp_ready [3];
    word_t w_data;
    strb_t w_strb;
    word_t sw;
    wire logic  req_ready [3];
    wire logic  rsp_valid [3];
    wire id_t   rsp_id [3];
    wire word_t rsp_data [3];
    wire word_t led;

    logic [31:0] lfsr = 32'h0d0a09b9;
    word_t       model_mem [16]; // one word per 4 KiB block of the itcm
    word_t       model_led;
    logic        m1_done;
    logic        aborted;
    int          value_errs;
    int          other_errs;

    assign rsp_data[2] = '0; // write responses carry no data

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mems u_mems (
        .clk         (clk),          .rst_n      (rst_n),
        .m0_ar_valid (req_valid[0]), .m0_ar_id   (req_id[0]),    .m0_ar_addr (req_addr[0]),
        .m0_ar_ready (req_ready[0]), .m0_r_valid (rsp_valid[0]), .m0_r_id    (rsp_id[0]),
        .m0_r_data   (rsp_data[0]),  .m0_r_ready (rsp_ready[0]),
        .m1_ar_valid (req_valid[1]), .m1_ar_id   (req_id[1]),    .m1_ar_addr (req_addr[1]),
        .m1_ar_ready (req_ready[1]), .m1_r_valid (rsp_valid[1]), .m1_r_id    (rsp_id[1]),
        .m1_r_data   (rsp_data[1]),  .m1_r_ready (rsp_ready[1]),
        .m1_aw_valid (req_valid[2]), .m1_aw_id   (req_id[2]),    .m1_aw_addr (req_addr[2]),
        .m1_w_data   (w_data),       .m1_w_strb  (w_strb),       .m1_w_valid (req_valid[2]),
        .m1_w_ready  (req_ready[2]), .m1_b_valid (rsp_valid[2]), .m1_b_id    (rsp_id[2]),
        .m1_b_ready  (rsp_ready[2]),
        .sw          (sw),           .led        (led)
    );

    // galois lfsr with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic addr_t slot_addr(input int k);
        return ITCM_BASE + addr_t'(k * 32'h1004); // spreads slots over the whole RAM
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input strb_t strb);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[b*8 +: 8] = data[b*8 +: 8];
        end
        return r;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s id expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[FAIL] %s led expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic protocol_error(input string what);
        other_errs++;
        $display("ERROR at time %0t: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("value errors: %0d, protocol and timeout errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // stops all traffic, the run then ends through the normal report
    task automatic timed_out(input string what);
        protocol_error({"timeout waiting for ", what});
        aborted = 1'b1;
    endtask

    // called and returns 1 unit after a rising edge
    task automatic transfer(input int ch, input addr_t addr, input id_t id,
                            input word_t exp, input string name);
        int    n;
        logic  got;
        logic  held;
        id_t   hold_id;
        word_t hold_data;
        req_valid[ch] = 1'b1;
        req_id[ch]    = id;
        req_addr[ch]  = addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (rsp_valid[ch] !== 1'b0) protocol_error({name, ": response with none in flight"});
        end while (!req_ready[ch] && n < 200);
        if (!req_ready[ch]) begin
            timed_out({name, " request handshake"});
        end else begin
            got  = 1'b0;
            held = 1'b0;
            for (n = 0; n < 200 && !got; n++) begin
                @(posedge clk);
                #1;
                req_valid[ch] = 1'b0;
                rsp_ready[ch] = take_bits(1); // random back-pressure
                @(negedge clk);
                if (n == 0 && !rsp_valid[ch]) begin
                    protocol_error({name, ": response not one cycle after the request"});
                end
                if (held && (!rsp_valid[ch] || rsp_id[ch] !== hold_id
                             || rsp_data[ch] !== hold_data)) begin
                    protocol_error({name, ": response changed while stalled"});
                end
                held      = rsp_valid[ch] && !rsp_ready[ch];
                hold_id   = rsp_id[ch];
                hold_data = rsp_data[ch];
                got       = rsp_valid[ch] && rsp_ready[ch];
            end
            if (!got) begin
                timed_out({name, " response"});
            end else begin
                check_id(name, id, rsp_id[ch]);
                if (ch < 2) check_word(name, exp, rsp_data[ch]);
                @(posedge clk);
                #1 rsp_ready[ch] = 1'b0;
            end
        end
    endtask

    task automatic run_m0();
        int k;
        while (!m1_done && !aborted) begin
            k = int'(take_bits(3));
            transfer(0, slot_addr(k), id_t'(take_bits(2)), model_mem[k], "concurrent m0 read");
        end
    endtask

    task automatic run_m1();
        int    k;
        id_t   id;
        word_t data;
        strb_t strb;
        for (int i = 0; i < 300 && !aborted; i++) begin
            id   = id_t'(take_bits(2));
            data = take_bits(32);
            strb = strb_t'(take_bits(4));
            case (take_bits(3))
                0, 1: begin
                    k      = 8 + int'(take_bits(3));
                    w_data = data;
                    w_strb = strb;
                    transfer(2, slot_addr(k), id, '0, "itcm write");
                    model_mem[k] = merge_bytes(model_mem[k], data, strb);
                end
                2, 3: begin
                    k = int'(take_bits(4));
                    transfer(1, slot_addr(k), id, model_mem[k], "itcm read-back");
                end
                4: begin
                    w_data = data;
                    w_strb = strb;
                    transfer(2, PERIP_BASE + LED_OFFSET, id, '0, "led write");
                    model_led = merge_bytes(model_led, data, strb);
                    if (!aborted) check_led("led write", model_led, led);
                end
                5: transfer(1, PERIP_BASE + LED_OFFSET, id, model_led, "led read");
                default: begin
                    sw = data; // stays put until the next switch read
                    transfer(1, PERIP_BASE + SW_OFFSET, id, data, "switch read");
                end
            endcase
        end
        m1_done = 1'b1;
    endtask

    initial begin
        int n;
        for (int c = 0; c < 3; c++) begin
            req_valid[c] = 1'b0;
            req_id[c]    = '0;
            req_addr[c]  = '0;
            rsp_ready[c] = 1'b0;
        end
        w_data     = '0;
        w_strb     = '0;
        sw         = '0;
        model_led  = '0;
        m1_done    = 1'b0;
        aborted    = 1'b0;
        value_errs = 0;
        other_errs = 0;

        // last pass of this loop lands just after reset release
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (rsp_valid[0] !== 1'b0 || rsp_valid[1] !== 1'b0 || rsp_valid[2] !== 1'b0) begin
                protocol_error("response valid high in or just after reset");
            end
            check_led("reset", '0, led);
        end while (!rst_n && n < 200);
        if (!rst_n) begin
            timed_out("reset release");
        end else begin
            @(posedge clk);
            #1;

            // every slot fully written before anyone reads it
            for (int k = 0; k < 16 && !aborted; k++) begin
                model_mem[k] = take_bits(32);
                w_data       = model_mem[k];
                w_strb       = 4'hf;
                transfer(2, slot_addr(k), id_t'(k), '0, "itcm fill");
            end

            if (!aborted) begin
                fork
                    run_m0();
                    run_m1();
                join
            end
        end
        finish_run();
    end

endmodule

// ==== tb_clk_gen.sv ====
// free-running clock, period 10 time units
// rst_n held low for the first 16 rising edges, released just after an edge
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== mems.sv ====
// memory subsystem top, fetch port m0 and data port m1 onto itcm and peripherals
// single-beat transfers; responses one cycle after the request handshake
module mems
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  m0_ar_valid,
    input  id_t   m0_ar_id,
    input  addr_t m0_ar_addr,
    output logic  m0_ar_ready,
    output logic  m0_r_valid,
    output id_t   m0_r_id,
    output word_t m0_r_data,
    input  logic  m0_r_ready,
    input  logic  m1_ar_valid,
    input  id_t   m1_ar_id,
    input  addr_t m1_ar_addr,
    output logic  m1_ar_ready,
    output logic  m1_r_valid,
    output id_t   m1_r_id,
    output word_t m1_r_data,
    input  logic  m1_r_ready,
    input  logic  m1_aw_valid,
    input  id_t   m1_aw_id,
    input  addr_t m1_aw_addr,
    input  word_t m1_w_data,
    input  strb_t m1_w_strb,
    input  logic  m1_w_valid,
    output logic  m1_w_ready,
    output logic  m1_b_valid,
    output id_t   m1_b_id,
    input  logic  m1_b_ready,
    input  word_t sw,
    output word_t led
);

    // itcm side
    logic       itcm_ar_valid, itcm_ar_ready, itcm_r_valid, itcm_r_ready;
    id_t        itcm_ar_id, itcm_r_id, itcm_b_id;
    itcm_addr_t itcm_ar_addr, itcm_w_addr;
    word_t      itcm_r_data;
    logic       itcm_w_valid, itcm_w_ready, itcm_b_valid, itcm_b_ready;

    // peripheral side
    logic  perip_ar_valid, perip_ar_ready, perip_r_valid, perip_r_ready;
    id_t   perip_ar_id, perip_r_id, perip_b_id;
    addr_t perip_ar_addr, perip_w_addr;
    word_t perip_r_data;
    logic  perip_w_valid, perip_w_ready, perip_b_valid, perip_b_ready;

    // write payload shared by both targets
    id_t   w_id;
    word_t w_data;
    strb_t w_strb;

    read_router  u_read_router  (.*);
    write_router u_write_router (.*);

    itcm_ram u_itcm_ram (
        .clk      (clk),           .rst_n    (rst_n),
        .ar_valid (itcm_ar_valid), .ar_id    (itcm_ar_id),    .ar_addr (itcm_ar_addr),
        .ar_ready (itcm_ar_ready), .r_valid  (itcm_r_valid),  .r_id    (itcm_r_id),
        .r_data   (itcm_r_data),   .r_ready  (itcm_r_ready),
        .w_valid  (itcm_w_valid),  .w_id     (w_id),          .w_addr  (itcm_w_addr),
        .w_data   (w_data),        .w_strb   (w_strb),        .w_ready (itcm_w_ready),
        .b_valid  (itcm_b_valid),  .b_id     (itcm_b_id),     .b_ready (itcm_b_ready)
    );

    perip_regs u_perip_regs (
        .clk      (clk),            .rst_n    (rst_n),
        .ar_valid (perip_ar_valid), .ar_id    (perip_ar_id),   .ar_addr (perip_ar_addr),
        .ar_ready (perip_ar_ready), .r_valid  (perip_r_valid), .r_id    (perip_r_id),
        .r_data   (perip_r_data),   .r_ready  (perip_r_ready),
        .w_valid  (perip_w_valid),  .w_id     (w_id),          .w_addr  (perip_w_addr),
        .w_data   (w_data),         .w_strb   (w_strb),        .w_ready (perip_w_ready),
        .b_valid  (perip_b_valid),  .b_id     (perip_b_id),    .b_ready (perip_b_ready),
        .sw       (sw),             .led      (led)
    );

endmodule

// ==== perip_regs.sv ====
// peripheral slave, led register at LED_OFFSET and switch input at SW_OFFSET
// other offsets read zero and drop writes
module perip_regs
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ar_valid,
    input  id_t   ar_id,
    input  addr_t ar_addr,
    output logic  ar_ready,
    output logic  r_valid,
    output id_t   r_id,
    output word_t r_data,
    input  logic  r_ready,
    input  logic  w_valid,
    input  id_t   w_id,
    input  addr_t w_addr,
    input  word_t w_data,
    input  strb_t w_strb,
    output logic  w_ready,
    output logic  b_valid,
    output id_t   b_id,
    input  logic  b_ready,
    input  word_t sw,
    output word_t led
);

    addr_t rd_off, wr_off;
    logic  rd_fire, wr_fire;

    assign rd_off   = ar_addr - PERIP_BASE;
    assign wr_off   = w_addr - PERIP_BASE;
    assign ar_ready = !r_valid || r_ready;
    assign w_ready  = !b_valid || b_ready;
    assign rd_fire  = ar_valid && ar_ready;
    assign wr_fire  = w_valid && w_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            led     <= '0;
        end else begin
            r_valid <= rd_fire || (r_valid && !r_ready);
            b_valid <= wr_fire || (b_valid && !b_ready);
            if (wr_fire && wr_off == LED_OFFSET) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) led[b*8 +: 8] <= w_data[b*8 +: 8];
                end
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_id   <= ar_id;
            r_data <= (rd_off == LED_OFFSET) ? led :
                      (rd_off == SW_OFFSET)  ? sw  : '0; // switches sampled live
        end
        if (wr_fire) b_id <= w_id;
    end

endmodule

// ==== itcm_ram.sv ====
// single-beat instruction RAM, byte strobes, one registered response per channel
// no init file; a read and write to one word in the same cycle return the old word
module itcm_ram
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // read channel
    input  logic       ar_valid,
    input  id_t        ar_id,
    input  itcm_addr_t ar_addr,
    output logic       ar_ready,
    output logic       r_valid,
    output id_t        r_id,
    output word_t      r_data,
    input  logic       r_ready,
    // write channel
    input  logic       w_valid,
    input  id_t        w_id,
    input  itcm_addr_t w_addr,
    input  word_t      w_data,
    input  strb_t      w_strb,
    output logic       w_ready,
    output logic       b_valid,
    output id_t        b_id,
    input  logic       b_ready
);

    word_t mem [ITCM_WORDS];

    logic rd_fire, wr_fire;

    // slot free, or emptied this cycle
    assign ar_ready = !r_valid || r_ready;
    assign w_ready  = !b_valid || b_ready;
    assign rd_fire  = ar_valid && ar_ready;
    assign wr_fire  = w_valid && w_ready;

    // read side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (rd_fire) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            r_data <= mem[ar_addr[15:2]]; // word index
            r_id   <= ar_id;
        end
    end

    // write side
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (w_strb[b]) begin
                    mem[w_addr[15:2]][b*8 +: 8] <= w_data[b*8 +: 8];
                end
            end
            b_id <= w_id;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
        end else if (wr_fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

endmodule

// ==== write_router.sv ====
// write path for master 1, address and data arrive together
// one target at a time may hold open writes, responses steered by counters
module write_router
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // master 1
    input  logic       m1_aw_valid,
    input  id_t        m1_aw_id,
    input  addr_t      m1_aw_addr,
    input  word_t      m1_w_data,
    input  strb_t      m1_w_strb,
    input  logic       m1_w_valid,
    output logic       m1_w_ready,  // shared by address and data
    output logic       m1_b_valid,
    output id_t        m1_b_id,
    input  logic       m1_b_ready,
    // itcm target
    output logic       itcm_w_valid,
    output itcm_addr_t itcm_w_addr,
    input  logic       itcm_w_ready,
    input  logic       itcm_b_valid,
    input  id_t        itcm_b_id,
    output logic       itcm_b_ready,
    // peripheral target
    output logic       perip_w_valid,
    output addr_t      perip_w_addr,
    input  logic       perip_w_ready,
    input  logic       perip_b_valid,
    input  id_t        perip_b_id,
    output logic       perip_b_ready,
    // shared to both targets
    output id_t        w_id,
    output word_t      w_data,
    output strb_t      w_strb
);

    cnt_t itcm_cnt, perip_cnt;
    logic itcm_busy, perip_busy;
    logic wr_valid;

    assign wr_valid = m1_aw_valid && m1_w_valid;

    // held off while the other target still owes a response
    assign itcm_w_valid  = wr_valid && is_itcm(m1_aw_addr) && !perip_busy;
    assign perip_w_valid = wr_valid && is_perip(m1_aw_addr) && !itcm_busy;

    assign itcm_w_addr  = itcm_addr_t'(m1_aw_addr - ITCM_BASE);
    assign perip_w_addr = m1_aw_addr;
    assign w_id         = m1_aw_id;
    assign w_data       = m1_w_data;
    assign w_strb       = m1_w_strb;

    assign m1_w_ready = (itcm_w_valid && itcm_w_ready) || (perip_w_valid && perip_w_ready);

    assign m1_b_valid    = (itcm_busy && itcm_b_valid) || (perip_busy && perip_b_valid);
    assign m1_b_id       = itcm_busy ? itcm_b_id : perip_b_id;
    assign itcm_b_ready  = itcm_busy && m1_b_ready;
    assign perip_b_ready = perip_busy && m1_b_ready;

    outstanding_counter u_itcm_w_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (itcm_w_valid && itcm_w_ready),
        .retire (itcm_b_valid && itcm_b_ready),
        .count  (itcm_cnt),
        .busy   (itcm_busy)
    );

    outstanding_counter u_perip_w_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (perip_w_valid && perip_w_ready),
        .retire (perip_b_valid && perip_b_ready),
        .count  (perip_cnt),
        .busy   (perip_busy)
    );

    // master presents address and data as one beat
    a_aw_w_paired: assert property (@(posedge clk) disable iff (!rst_n)
        m1_aw_valid == m1_w_valid);

    a_w_single_target: assert property (@(posedge clk) disable iff (!rst_n)
        !((itcm_cnt != '0) && (perip_cnt != '0)));

endmodule

// ==== read_router.sv ====
// read crossbar for the fetch port (m0) and the data port (m1)
// m0 reaches itcm only; m1 wins itcm ties; responses steered by counters
module read_router
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // master 0, instruction fetch
    input  logic       m0_ar_valid,
    input  id_t        m0_ar_id,
    input  addr_t      m0_ar_addr,
    output logic       m0_ar_ready,
    output logic       m0_r_valid,
    output id_t        m0_r_id,
    output word_t      m0_r_data,
    input  logic       m0_r_ready,
    // master 1, data port
    input  logic       m1_ar_valid,
    input  id_t        m1_ar_id,
    input  addr_t      m1_ar_addr,
    output logic       m1_ar_ready,
    output logic       m1_r_valid,
    output id_t        m1_r_id,
    output word_t      m1_r_data,
    input  logic       m1_r_ready,
    // itcm target
    output logic       itcm_ar_valid,
    output id_t        itcm_ar_id,
    output itcm_addr_t itcm_ar_addr,
    input  logic       itcm_ar_ready,
    input  logic       itcm_r_valid,
    input  id_t        itcm_r_id,
    input  word_t      itcm_r_data,
    output logic       itcm_r_ready,
    // peripheral target
    output logic       perip_ar_valid,
    output id_t        perip_ar_id,
    output addr_t      perip_ar_addr,
    input  logic       perip_ar_ready,
    input  logic       perip_r_valid,
    input  id_t        perip_r_id,
    input  word_t      perip_r_data,
    output logic       perip_r_ready
);

    cnt_t m0_itcm_cnt, m1_itcm_cnt, m1_perip_cnt;
    logic m0_itcm_busy, m1_itcm_busy, m1_perip_busy;
    logic m1_itcm_req, m1_perip_req;
    logic m0_grant, m1_itcm_grant, m1_perip_grant;
    addr_t itcm_sel_addr;

    assign m1_itcm_req  = m1_ar_valid && is_itcm(m1_ar_addr);
    assign m1_perip_req = m1_ar_valid && is_perip(m1_ar_addr);

    // a master never shares a return path with another owner in flight
    assign m1_itcm_grant  = m1_itcm_req && !m0_itcm_busy && !m1_perip_busy;
    assign m1_perip_grant = m1_perip_req && !m1_itcm_busy;
    assign m0_grant       = m0_ar_valid && is_itcm(m0_ar_addr)
                            && !m1_itcm_req && !m1_itcm_busy;

    // itcm request mux, m1 first
    assign itcm_ar_valid = m1_itcm_grant || m0_grant;
    assign itcm_ar_id    = m1_itcm_grant ? m1_ar_id : m0_ar_id;
    assign itcm_sel_addr = m1_itcm_grant ? m1_ar_addr : m0_ar_addr;
    assign itcm_ar_addr  = itcm_addr_t'(itcm_sel_addr - ITCM_BASE);

    assign perip_ar_valid = m1_perip_grant;
    assign perip_ar_id    = m1_ar_id;
    assign perip_ar_addr  = m1_ar_addr;

    assign m0_ar_ready = m0_grant && itcm_ar_ready;
    assign m1_ar_ready = (m1_itcm_grant && itcm_ar_ready)
                         || (m1_perip_grant && perip_ar_ready);

    // response steering
    assign m0_r_valid = m0_itcm_busy && itcm_r_valid;
    assign m0_r_id    = itcm_r_id;
    assign m0_r_data  = itcm_r_data;

    assign m1_r_valid = (m1_itcm_busy && itcm_r_valid) || (m1_perip_busy && perip_r_valid);
    assign m1_r_id    = m1_itcm_busy ? itcm_r_id : perip_r_id;
    assign m1_r_data  = m1_itcm_busy ? itcm_r_data : perip_r_data;

    assign itcm_r_ready  = m0_itcm_busy ? m0_r_ready : (m1_itcm_busy && m1_r_ready);
    assign perip_r_ready = m1_perip_busy && m1_r_ready;

    outstanding_counter u_m0_itcm_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (m0_ar_valid && m0_ar_ready),
        .retire (m0_r_valid && m0_r_ready),
        .count  (m0_itcm_cnt),
        .busy   (m0_itcm_busy)
    );

    outstanding_counter u_m1_itcm_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (m1_itcm_grant && itcm_ar_ready),
        .retire (m1_itcm_busy && itcm_r_valid && m1_r_ready),
        .count  (m1_itcm_cnt),
        .busy   (m1_itcm_busy)
    );

    outstanding_counter u_m1_perip_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (m1_perip_grant && perip_ar_ready),
        .retire (perip_r_valid && perip_r_ready),
        .count  (m1_perip_cnt),
        .busy   (m1_perip_busy)
    );

    // itcm read data has exactly one owner at any time
    a_itcm_single_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !((m0_itcm_cnt != '0) && (m1_itcm_cnt != '0)));

    // m1 never has reads open at both targets
    a_m1_single_target: assert property (@(posedge clk) disable iff (!rst_n)
        !((m1_itcm_cnt != '0) && (m1_perip_cnt != '0)));

endmodule

// ==== outstanding_counter.sv ====
// up/down count of transactions in flight for one master and one target
// issue and retire in the same cycle leave the count unchanged
module outstanding_counter
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic issue,
    input  logic retire,
    output cnt_t count,
    output logic busy
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (issue && !retire) begin
            count <= count + 1'b1;
        end else if (retire && !issue) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // the issuing side must stop before the count wraps
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        issue && !retire |-> count != CNT_MAX);

    // a response only comes back for a request that went out earlier
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> busy);

endmodule

// ==== mem_pkg.sv ====
// address map and field widths shared by routers and targets
// regions are fixed, anything outside both is never accepted
package mem_pkg;

    typedef logic [31:0] addr_t;      // bus byte address
    typedef logic [31:0] word_t;      // data word, led and switch values
    typedef logic [3:0]  strb_t;      // byte write strobes
    typedef logic [1:0]  id_t;        // echoed transaction id
    typedef logic [15:0] itcm_addr_t; // byte offset inside itcm
    typedef logic [3:0]  cnt_t;       // outstanding transaction count

    // instruction memory region
    localparam addr_t ITCM_BASE  = 32'h8000_0000;
    localparam addr_t ITCM_SIZE  = 32'h0001_0000; // 64 KiB
    localparam int    ITCM_WORDS = 16384;

    // peripheral region, end is exclusive
    localparam addr_t PERIP_BASE = 32'h1000_0000;
    localparam addr_t PERIP_END  = 32'h1000_1000;
    localparam addr_t LED_OFFSET = 32'h0000_0000;
    localparam addr_t SW_OFFSET  = 32'h0000_0004;

    localparam cnt_t CNT_MAX = 4'd15;

    function automatic logic is_itcm(input addr_t addr);
        return (addr >= ITCM_BASE) && (addr < (ITCM_BASE + ITCM_SIZE));
    endfunction

    function automatic logic is_perip(input addr_t addr);
        return (addr >= PERIP_BASE) && (addr < PERIP_END);
    endfunction

endpackage
